// File: mul_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the multiply unit
// Operation codes, XLEN encoding and the latency limit
////////////////////////////////////////////////////////////////////////////

package mul_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Operation codes
  //////////////////////////////////////////////////////////////////////////

  // Already classified by the decoder
  // OP_OTHER covers every non-multiply instruction
  typedef enum logic [2:0]
  {
    OP_OTHER  = 3'd0,
    OP_MUL    = 3'd1,
    // Upper half, signed x signed
    OP_MULH   = 3'd2,
    // Upper half, signed x unsigned
    OP_MULHSU = 3'd3,
    // Upper half, unsigned x unsigned
    OP_MULHU  = 3'd4,
    // 32 bit multiply, sign extended result, RV64 only
    OP_MULW   = 3'd5
  } mul_op_e;

  //////////////////////////////////////////////////////////////////////////
  // Machine XLEN
  //////////////////////////////////////////////////////////////////////////

  // Same encoding as the MXL field of misa
  // 2'b11 would be RV128, not supported here
  typedef enum logic [1:0]
  {
    RV32I = 2'b01,
    RV64I = 2'b10
  } xlen_e;

  //////////////////////////////////////////////////////////////////////////
  // Latency
  //////////////////////////////////////////////////////////////////////////

  // Extra cycles beyond the result register
  localparam int MAX_LATENCY = 3;

endpackage

// File: mul_issue_if.sv
////////////////////////////////////////////////////////////////////////////
// Issue bus from operand preparation to the multiplier datapath
// Conditioned operands, operation and sign correction flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface mul_issue_if #(
  parameter int MXLEN = 64
);
  import mul_pkg::*;

  // Operation, kept for the result select
  mul_op_e            op;
  // Absolute value operands
  logic [MXLEN-1:0]   opa;
  logic [MXLEN-1:0]   opb;
  // Product must be negated
  logic               neg;

  // No handshake, sampled when control raises load
  modport source (output op, output opa, output opb, output neg);
  modport sink   (input  op, input  opa, input  opb, input  neg);

endinterface

// File: mul_operand_prep.sv
////////////////////////////////////////////////////////////////////////////
// Multiply operand preparation
// Absolute value operands, negate flag and legal multiply detection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_operand_prep #(
  parameter int MXLEN = 64
)
(
  input  mul_pkg::mul_op_e   op_i,
  input  mul_pkg::xlen_e     xlen_i,
  input  logic [MXLEN-1:0]   opa_i,
  input  logic [MXLEN-1:0]   opb_i,
  output logic               is_mul_o,
  mul_issue_if.source        iss_o
);
  import mul_pkg::*;

  // Two's complement magnitude
  function automatic logic [MXLEN-1:0] abs_val(input logic [MXLEN-1:0] a);
    return a[MXLEN-1] ? (~a + MXLEN'(1)) : a;
  endfunction

  // Low words sign extended, used by MULW
  logic [MXLEN-1:0] opa_w;
  logic [MXLEN-1:0] opb_w;

  assign opa_w = MXLEN'(signed'(opa_i[31:0]));
  assign opb_w = MXLEN'(signed'(opb_i[31:0]));

  assign iss_o.op = op_i;

  //////////////////////////////////////////////////////////////////////////
  // One unsigned multiply for every form
  //////////////////////////////////////////////////////////////////////////

  // Operand A, unsigned only for MULHU
  always_comb
  begin
    case (op_i)
      OP_MULW:  iss_o.opa = abs_val(opa_w);
      OP_MULHU: iss_o.opa = opa_i;
      default:  iss_o.opa = abs_val(opa_i);
    endcase
  end

  // Operand B, unsigned for MULHSU and MULHU
  always_comb
  begin
    case (op_i)
      OP_MULW:   iss_o.opb = abs_val(opb_w);
      OP_MULHSU: iss_o.opb = opb_i;
      OP_MULHU:  iss_o.opb = opb_i;
      default:   iss_o.opb = abs_val(opb_i);
    endcase
  end

  // Product sign from the signed positions only
  always_comb
  begin
    case (op_i)
      OP_MUL,
      OP_MULH:   iss_o.neg = opa_i[MXLEN-1] ^ opb_i[MXLEN-1];
      OP_MULHSU: iss_o.neg = opa_i[MXLEN-1];
      OP_MULW:   iss_o.neg = opa_i[31] ^ opb_i[31];
      default:   iss_o.neg = 1'b0;
    endcase
  end

  // MULW exists on RV64 only
  always_comb
  begin
    case (op_i)
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: is_mul_o = 1'b1;
      OP_MULW: is_mul_o = (xlen_i == RV64I);
      default: is_mul_o = 1'b0;
    endcase
  end

endmodule

// File: mul_datapath.sv
////////////////////////////////////////////////////////////////////////////
// Multiplier datapath
// Input registers, unsigned multiply, sign fix, latency pipeline and
// final result select register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_datapath #(
  parameter int MXLEN        = 64,
  parameter int MULT_LATENCY = 2
)
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               load_i,
  input  logic               mem_stall_i,
  mul_issue_if.sink          iss_i,
  output logic [MXLEN-1:0]   result_o
);
  import mul_pkg::*;

  localparam int DXLEN   = 2 * MXLEN;
  localparam int LATENCY = (MULT_LATENCY > MAX_LATENCY) ? MAX_LATENCY : MULT_LATENCY;

  if (MULT_LATENCY > MAX_LATENCY)
  begin : g_clip_warn
    $warning("MULT_LATENCY %0d clipped to %0d", MULT_LATENCY, MAX_LATENCY);
  end

  mul_op_e            op_q;
  logic               neg_q;
  logic [MXLEN-1:0]   opa_q;
  logic [MXLEN-1:0]   opb_q;
  logic [DXLEN-1:0]   prod;
  logic [DXLEN-1:0]   prod_q;
  logic [DXLEN-1:0]   corr;
  logic [DXLEN-1:0]   corr_q;

  //////////////////////////////////////////////////////////////////////////
  // Input stage
  //////////////////////////////////////////////////////////////////////////

  if (LATENCY == 0)
  begin : g_in_bypass
    // Single cycle path straight from operand preparation
    assign op_q  = iss_i.op;
    assign neg_q = iss_i.neg;
    assign opa_q = iss_i.opa;
    assign opb_q = iss_i.opb;
  end
  else
  begin : g_in_reg
    // Operation register feeding the result select
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
        op_q <= OP_OTHER;
      else if (load_i)
        op_q <= iss_i.op;
    end

    always_ff @(posedge clk_i)
    begin
      if (load_i)
      begin
        neg_q <= iss_i.neg;
        opa_q <= iss_i.opa;
        opb_q <= iss_i.opb;
      end
    end
  end

  // Unsigned product of the magnitudes
  assign prod = DXLEN'(opa_q) * DXLEN'(opb_q);

  //////////////////////////////////////////////////////////////////////////
  // Latency pipeline frozen under memory back-pressure
  //////////////////////////////////////////////////////////////////////////

  if (LATENCY >= 2)
  begin : g_prod_reg
    always_ff @(posedge clk_i)
    begin
      if (!mem_stall_i)
        prod_q <= prod;
    end
  end
  else
  begin : g_prod_bypass
    assign prod_q = prod;
  end

  // Restore the sign
  assign corr = neg_q ? (~prod_q + DXLEN'(1)) : prod_q;

  if (LATENCY == 3)
  begin : g_corr_reg
    always_ff @(posedge clk_i)
    begin
      if (!mem_stall_i)
        corr_q <= corr;
    end
  end
  else
  begin : g_corr_bypass
    assign corr_q = corr;
  end

  // Result slice sampled on every edge
  always_ff @(posedge clk_i)
  begin
    case (op_q)
      OP_MUL:  result_o <= corr_q[MXLEN-1:0];
      OP_MULW: result_o <= MXLEN'(signed'(corr_q[31:0]));
      default: result_o <= corr_q[DXLEN-1:MXLEN];
    endcase
  end

endmodule

// File: mul_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Multiplier control
// Idle/wait FSM with latency counter, makes load, stall and bubble
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_ctrl #(
  parameter int MULT_LATENCY = 2
)
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ex_stall_i,
  input  logic mem_stall_i,
  input  logic bubble_i,
  input  logic is_mul_i,
  output logic load_o,
  output logic mul_stall_o,
  output logic mul_bubble_o
);
  import mul_pkg::*;

  localparam int LATENCY  = (MULT_LATENCY > MAX_LATENCY) ? MAX_LATENCY : MULT_LATENCY;
  localparam int CNT_W    = $clog2(MAX_LATENCY);
  localparam int CNT_INIT = (LATENCY > 0) ? LATENCY - 1 : 0;

  if (MULT_LATENCY > MAX_LATENCY)
  begin : g_clip_warn
    $warning("MULT_LATENCY %0d clipped to %0d", MULT_LATENCY, MAX_LATENCY);
  end

  typedef enum logic {ST_IDLE, ST_WAIT} state_e;

  state_e             state;
  logic [CNT_W-1:0]   cnt;

  // Accept a legal multiply while idle and the pipe moves
  assign load_o = (state == ST_IDLE) & ~ex_stall_i & ~bubble_i & is_mul_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state        <= ST_IDLE;
      cnt          <= '0;
      mul_stall_o  <= 1'b0;
      mul_bubble_o <= 1'b1;
    end
    else
    begin
      // Result strobe lasts one cycle
      mul_bubble_o <= 1'b1;

      case (state)
        ST_IDLE:
        begin
          if (load_o)
          begin
            if (LATENCY == 0)
              mul_bubble_o <= 1'b0;
            else
            begin
              state       <= ST_WAIT;
              cnt         <= CNT_W'(CNT_INIT);
              mul_stall_o <= 1'b1;
            end
          end
        end

        ST_WAIT:
        begin
          // Counter steps with the pipeline registers
          if (!mem_stall_i)
          begin
            if (cnt != '0)
              cnt <= cnt - 1'b1;
            else
            begin
              state        <= ST_IDLE;
              mul_stall_o  <= 1'b0;
              mul_bubble_o <= 1'b0;
            end
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: mul_unit.sv
////////////////////////////////////////////////////////////////////////////
// Multiply unit top level
// Operand preparation, datapath and control, plain ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_unit #(
  parameter int MXLEN        = 64,
  parameter int MULT_LATENCY = 2
)
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ex_stall_i,
  input  logic               mem_stall_i,
  input  mul_pkg::mul_op_e   op_i,
  input  logic               bubble_i,
  input  logic [MXLEN-1:0]   opa_i,
  input  logic [MXLEN-1:0]   opb_i,
  input  mul_pkg::xlen_e     xlen_i,
  output logic               mul_stall_o,
  output logic               mul_bubble_o,
  output logic [MXLEN-1:0]   mul_r_o
);

  logic is_mul;
  logic load;

  // Conditioned operands toward the multiplier
  mul_issue_if #(.MXLEN(MXLEN)) iss_bus ();

  mul_operand_prep #(.MXLEN(MXLEN)) u_prep (
    .op_i     (op_i),
    .xlen_i   (xlen_i),
    .opa_i    (opa_i),
    .opb_i    (opb_i),
    .is_mul_o (is_mul),
    .iss_o    (iss_bus.source)
  );

  mul_datapath #(.MXLEN(MXLEN), .MULT_LATENCY(MULT_LATENCY)) u_datapath (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (load),
    .mem_stall_i (mem_stall_i),
    .iss_i       (iss_bus.sink),
    .result_o    (mul_r_o)
  );

  mul_ctrl #(.MULT_LATENCY(MULT_LATENCY)) u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ex_stall_i   (ex_stall_i),
    .mem_stall_i  (mem_stall_i),
    .bubble_i     (bubble_i),
    .is_mul_i     (is_mul),
    .load_o       (load),
    .mul_stall_o  (mul_stall_o),
    .mul_bubble_o (mul_bubble_o)
  );

endmodule

// File: mul_unit_assert.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the multiply unit control outputs
// Bound into the RTL top level from the testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_unit_assert
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ex_stall_i,
  input  logic bubble_i,
  input  logic mul_stall_o,
  input  logic mul_bubble_o
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // No result strobe while the pipeline is held
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !(mul_stall_o && !mul_bubble_o))
  else
  begin
    fail_count++;
    $error("mul_bubble_o low while mul_stall_o high");
  end

  // Strobe lasts exactly one cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !mul_bubble_o |=> mul_bubble_o)
  else
  begin
    fail_count++;
    $error("mul_bubble_o low for two cycles in a row");
  end

  // Stall only starts on a real, unstalled instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   $rose(mul_stall_o) |-> $past(!bubble_i && !ex_stall_i))
  else
  begin
    fail_count++;
    $error("mul_stall_o rose without an accepted instruction");
  end

endmodule

// File: mul_unit_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the multiply unit
// Stimulus table with expected values, LFSR operands and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_unit_tb;
  import mul_pkg::*;

  localparam int          LATENCY = 2;
  localparam logic [63:0] MIN_VAL = 64'h8000_0000_0000_0000;
  localparam logic [63:0] ONES    = 64'hffff_ffff_ffff_ffff;

  // One table row with stimulus and expected outcome
  typedef struct packed {
    mul_op_e     op;
    xlen_e       xlen;
    logic [63:0] a;
    logic [63:0] b;
    int          ex_cyc;
    int          mem_cyc;
    logic        bub;
    logic        legal;
    logic [63:0] exp;
  } entry_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        ex_stall_i;
  logic        mem_stall_i;
  logic        bubble_i;
  mul_op_e     op_i;
  xlen_e       xlen_i;
  logic [63:0] opa_i;
  logic [63:0] opb_i;
  logic        mul_stall_o;
  logic        mul_bubble_o;
  logic [63:0] mul_r_o;

  entry_t      tbl[$];
  int          errors      = 0;
  int          watchdog_ns = 0;
  logic [31:0] lfsr        = 32'hb0ed_6475;

  always #4 clk_i = ~clk_i;

  mul_unit #(.MXLEN(64), .MULT_LATENCY(LATENCY)) dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ex_stall_i   (ex_stall_i),
    .mem_stall_i  (mem_stall_i),
    .op_i         (op_i),
    .bubble_i     (bubble_i),
    .opa_i        (opa_i),
    .opb_i        (opb_i),
    .xlen_i       (xlen_i),
    .mul_stall_o  (mul_stall_o),
    .mul_bubble_o (mul_bubble_o),
    .mul_r_o      (mul_r_o)
  );

  bind mul_unit mul_unit_assert u_assert (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ex_stall_i   (ex_stall_i),
    .bubble_i     (bubble_i),
    .mul_stall_o  (mul_stall_o),
    .mul_bubble_o (mul_bubble_o)
  );

  //////////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////////////////////////////

  // ISA product with signedness set by operand extension
  function automatic logic [63:0] ref_result(mul_op_e op, logic [63:0] a, logic [63:0] b);
    logic signed [127:0] xa;
    logic signed [127:0] xb;
    logic signed [127:0] p;
    xa = (op == OP_MULHU) ? {64'd0, a} : {{64{a[63]}}, a};
    xb = (op == OP_MULHSU || op == OP_MULHU) ? {64'd0, b} : {{64{b[63]}}, b};
    if (op == OP_MULW)
    begin
      xa = {{96{a[31]}}, a[31:0]};
      xb = {{96{b[31]}}, b[31:0]};
    end
    p = xa * xb;
    case (op)
      OP_MUL:  return p[63:0];
      OP_MULW: return {{32{p[31]}}, p[31:0]};
      default: return p[127:64];
    endcase
  endfunction

  // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
  function automatic logic [63:0] lfsr_take(int nbits);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      w    = {w[62:0], lfsr[0]};
    end
    return w;
  endfunction

  task automatic add_entry(mul_op_e op, xlen_e xl, logic [63:0] a, logic [63:0] b,
                           int ex_cyc, int mem_cyc, logic bub);
    logic legal;
    legal = !bub && ((op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU}) ||
                     (op == OP_MULW && xl == RV64I));
    tbl.push_back('{op, xl, a, b, ex_cyc, mem_cyc, bub, legal, ref_result(op, a, b)});
  endtask

  task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
    if (act !== exp)
    begin
      $display("CHECK FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // One table row through the DUT
  //////////////////////////////////////////////////////////////////////////

  task automatic run_entry(entry_t e);
    int   exp_e;
    int   n;
    int   edge_at;
    logic seen;
    // Strobe edge counted from the accepting edge
    exp_e   = (LATENCY == 0) ? 0 : LATENCY + e.mem_cyc;
    seen    = 1'b0;
    edge_at = -1;
    @(posedge clk_i);
    op_i       <= e.op;
    xlen_i     <= e.xlen;
    opa_i      <= e.a;
    opb_i      <= e.b;
    bubble_i   <= e.bub;
    ex_stall_i <= (e.ex_cyc > 0);
    // Nothing may start while EX stall holds it off
    for (int i = 0; i < e.ex_cyc; i++)
    begin
      @(posedge clk_i);
      if (i == e.ex_cyc - 1)
        ex_stall_i <= 1'b0;
      @(negedge clk_i);
      check_val("mul_stall_o", 64'(1'b0), 64'(mul_stall_o));
      check_val("mul_bubble_o", 64'(1'b1), 64'(mul_bubble_o));
    end
    // Accepting edge first and then the wait for the strobe
    for (n = 0; n <= exp_e + 2 && !seen; n++)
    begin
      @(posedge clk_i);
      bubble_i <= 1'b1;
      if (e.mem_cyc > 0 && n == LATENCY - 1)
        mem_stall_i <= 1'b1;
      if (e.mem_cyc > 0 && n == LATENCY - 1 + e.mem_cyc)
        mem_stall_i <= 1'b0;
      @(negedge clk_i);
      if (!mul_bubble_o)
      begin
        seen    = 1'b1;
        edge_at = n;
      end
      else if (!e.legal || n < exp_e)
        check_val("mul_stall_o", 64'(e.legal && LATENCY > 0), 64'(mul_stall_o));
    end
    if (e.legal && !seen)
    begin
      $display("No result strobe at %0d ns for op %0d", $time, e.op);
      errors++;
    end
    else if (e.legal)
    begin
      check_val("mul_bubble_o strobe edge", 64'(exp_e), 64'(edge_at));
      check_val("mul_stall_o", 64'(1'b0), 64'(mul_stall_o));
      check_val("mul_r_o", e.exp, mul_r_o);
    end
    else if (seen)
    begin
      $display("Result strobe at %0d ns for an instruction that must be ignored", $time);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////////

  initial
  begin
    int          max_stall;
    int unsigned afails;
    logic [63:0] ra;
    logic [63:0] rb;
    rst_ni      = 1'b0;
    ex_stall_i  = 1'b0;
    mem_stall_i = 1'b0;
    bubble_i    = 1'b1;
    op_i        = OP_OTHER;
    xlen_i      = RV64I;
    opa_i       = '0;
    opb_i       = '0;
    // Sign combinations with the most negative value and zero
    add_entry(OP_MUL,    RV64I, 64'd7, 64'hffff_ffff_ffff_fffd, 0, 0, 1'b0);
    add_entry(OP_MUL,    RV64I, 64'hffff_ffff_ffff_fffb, 64'hffff_ffff_ffff_fffa, 0, 0, 1'b0);
    add_entry(OP_MUL,    RV64I, MIN_VAL, ONES, 0, 0, 1'b0);
    add_entry(OP_MUL,    RV64I, 64'd0, ONES, 0, 0, 1'b0);
    add_entry(OP_MULH,   RV64I, ~MIN_VAL, ~MIN_VAL, 0, 0, 1'b0);
    add_entry(OP_MULH,   RV64I, MIN_VAL, 64'd3, 0, 0, 1'b0);
    add_entry(OP_MULH,   RV64I, 64'h0123_4567_89ab_cdef, 64'hffff_ffff_ffff_fffe, 0, 0, 1'b0);
    add_entry(OP_MULH,   RV64I, MIN_VAL, MIN_VAL, 0, 0, 1'b0);
    add_entry(OP_MULH,   RV64I, ONES, ONES, 0, 0, 1'b0);
    add_entry(OP_MULHSU, RV64I, ONES, ONES, 0, 0, 1'b0);
    add_entry(OP_MULHSU, RV64I, ~MIN_VAL, ONES, 0, 0, 1'b0);
    add_entry(OP_MULHSU, RV64I, MIN_VAL, 64'd0, 0, 0, 1'b0);
    add_entry(OP_MULHU,  RV64I, ONES, ONES, 0, 0, 1'b0);
    add_entry(OP_MULHU,  RV64I, MIN_VAL, 64'd2, 0, 0, 1'b0);
    add_entry(OP_MULW,   RV64I, 64'hdead_beef_8000_0000, ONES, 0, 0, 1'b0);
    add_entry(OP_MULW,   RV64I, 64'h1234_5678_0001_0000, 64'h0001_0000, 0, 0, 1'b0);
    add_entry(OP_MULW,   RV64I, 64'hffff_fff9, 64'd5, 0, 0, 1'b0);
    // No result expected
    add_entry(OP_MULW,   RV32I, 64'd3, 64'd4, 0, 0, 1'b0);
    add_entry(OP_OTHER,  RV64I, 64'd3, 64'd4, 0, 0, 1'b0);
    add_entry(OP_MUL,    RV64I, 64'd3, 64'd4, 0, 0, 1'b1);
    // EX stall and memory back-pressure
    add_entry(OP_MULH,   RV64I, MIN_VAL, 64'h1234_5678_9abc_def0, 3, 0, 1'b0);
    add_entry(OP_MULHSU, RV64I, 64'hfedc_ba98_7654_3210, ONES, 0, 4, 1'b0);
    add_entry(OP_MUL,    RV64I, ONES, 64'h7777_7777_7777_7777, 2, 2, 1'b0);
    for (int i = 0; i < 12; i++)
    begin
      ra = lfsr_take(64);
      rb = lfsr_take(64);
      add_entry(mul_op_e'(3'(i % 5 + 1)), RV64I, ra, rb,
                int'(lfsr_take(2)), int'(lfsr_take(2)), 1'b0);
    end
    max_stall = 0;
    foreach (tbl[i])
      if (tbl[i].ex_cyc + tbl[i].mem_cyc > max_stall)
        max_stall = tbl[i].ex_cyc + tbl[i].mem_cyc;
    watchdog_ns = tbl.size() * (MAX_LATENCY + max_stall + 4) * 8;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Idle outputs after reset
    @(negedge clk_i);
    check_val("mul_bubble_o", 64'(1'b1), 64'(mul_bubble_o));
    check_val("mul_stall_o", 64'(1'b0), 64'(mul_stall_o));
    foreach (tbl[i])
      run_entry(tbl[i]);
    afails = dut.u_assert.fail_count;
    $display("Summary: %0d check errors, %0d assertion failures", errors, afails);
    if (errors == 0 && afails == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("Watchdog expired, the tests did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: tb.f
mul_pkg.sv
mul_issue_if.sv
mul_operand_prep.sv
mul_datapath.sv
mul_ctrl.sv
mul_unit.sv
mul_unit_assert.sv
mul_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f tb.f --top-module mul_unit_tb -o mul_unit_sim
out=$(./obj_dir/mul_unit_sim || true)
echo "$out"
if echo "$out" | grep -q "^NO ERRORS$"; then
  exit 0
fi
exit 1
